// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module mem_access_tb -o mem_access_sim

output=$(./obj_dir/mem_access_sim || true)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

// ==== src.f ====
verilog/mem_pkg.sv
verilog/access_aligner.sv
verilog/lane_counter.sv
verilog/access_sequencer.sv
verilog/data_memory.sv
verilog/control_regs.sv
verilog/mem_access_unit.sv
testbench/mem_access_checker.sv
testbench/mem_access_tb.sv

// ==== testbench/mem_access_checker.sv ====
// Access sequencer assertions
module mem_access_checker
(
	input clk,
	input reset,
	input mem_pkg::seq_state_t state,
	input ready,
	input start,
	input misaligned,
	input mem_pkg::mem_result_t result
);

	// Vector holds ready low one cycle per lane, the last one in drain
	vector_ready_low: assert property (@(posedge clk) disable iff (reset)
		start |=> !ready ##(mem_pkg::num_lanes - 1) (!ready && state == mem_pkg::st_drain)
			##1 ready)
		else $error("ready not low for exactly one cycle per vector lane");

	// Misaligned scalar access ends in a faulting result
	misaligned_faults: assert property (@(posedge clk) disable iff (reset)
		misaligned |-> ##3 (result.valid && result.fault))
		else $error("misaligned access did not report a fault");

	// Faulting results carry no data
	fault_data_zero: assert property (@(posedge clk) disable iff (reset)
		(result.valid && result.fault) |-> result.data == '0)
		else $error("faulting result carries data");

	no_result_after_reset: assert property (@(posedge clk) $fell(reset) |-> !result.valid)
		else $error("result valid in the cycle after reset");

endmodule

bind access_sequencer mem_access_checker mem_access_checker_inst
(
	.clk(clk),
	.reset(reset),
	.state(state),
	.ready(ready),
	.start(start),
	.misaligned(misaligned),
	.result(result)
);

// ==== testbench/mem_access_tb.sv ====
// Load/store stage testbench
module mem_access_tb;

	localparam int mem_words = 64;
	localparam logic [31:0] core_id = 32'h0000_0c01;

	typedef struct packed
	{
		mem_pkg::mem_op_t op;
		logic [31:0] addr;
		logic [31:0] stride;
		logic [mem_pkg::num_lanes-1:0] mask;
		mem_pkg::vector_t value;
		logic squash;
	} row_t;

	typedef struct packed
	{
		mem_pkg::mem_result_t res;
		int due;	// Cycle the result must show up
		int row;
	} expect_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic squash = 1'b0;
	mem_pkg::mem_req_t req = '0;
	logic ready;
	mem_pkg::mem_result_t result;

	row_t rows[$];
	expect_t expq[$];
	expect_t got_entry;
	logic [7:0] ref_mem [mem_words*4];
	logic [31:0] ref_cr [4];
	logic [31:0] lfsr = 32'h1a63_00d9;
	int cycle = 0;
	int errors = 0;
	int errors_before;
	int limit_time = 0;
	mem_pkg::mem_op_t scalar_ops [8] = '{mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_lh,
		mem_pkg::op_lhu, mem_pkg::op_lw, mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw};

	mem_access_unit #(.mem_words(mem_words), .core_id(core_id)) mem_access_unit_inst
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.squash(squash),
		.ready(ready),
		.result(result)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// Taps 32, 22, 2, 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic logic [31:0] ref_word(input logic [7:0] a);
		logic [7:0] b;
		b = a & 8'hfc;
		return {ref_mem[b], ref_mem[b+8'd1], ref_mem[b+8'd2], ref_mem[b+8'd3]};
	endfunction

	function automatic void write_ref_word(input logic [7:0] a, input logic [31:0] w);
		logic [7:0] b;
		b = a & 8'hfc;
		ref_mem[b] = w[31:24];
		ref_mem[b+8'd1] = w[23:16];
		ref_mem[b+8'd2] = w[15:8];
		ref_mem[b+8'd3] = w[7:0];
	endfunction

	// Big-endian byte model of memory and registers
	function automatic mem_pkg::mem_result_t model_access(input row_t r);
		mem_pkg::mem_result_t res;
		logic [7:0] a;
		logic [31:0] w;
		logic [31:0] la;
		res = '0;
		res.valid = 1'b1;
		res.op = r.op;
		a = r.addr[7:0];
		w = r.value[0];
		case (r.op)
			mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: res.fault = 1'b0;
			mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: res.fault = r.addr[0];
			mem_pkg::op_vload_strided, mem_pkg::op_vstore_strided:
				res.fault = r.addr[1:0] != 2'b00 || r.stride[1:0] != 2'b00;
			default: res.fault = r.addr[1:0] != 2'b00;
		endcase
		if (!res.fault)
		begin
			case (r.op)
				mem_pkg::op_lb: res.data[0] = {{24{ref_mem[a][7]}}, ref_mem[a]};
				mem_pkg::op_lbu: res.data[0] = {24'd0, ref_mem[a]};
				mem_pkg::op_lh: res.data[0] = {{16{ref_mem[a][7]}}, ref_mem[a], ref_mem[a+8'd1]};
				mem_pkg::op_lhu: res.data[0] = {16'd0, ref_mem[a], ref_mem[a+8'd1]};
				mem_pkg::op_lw: res.data[0] = ref_word(a);
				mem_pkg::op_sb: ref_mem[a] = w[7:0];
				mem_pkg::op_sh:
				begin
					ref_mem[a] = w[15:8];
					ref_mem[a+8'd1] = w[7:0];
				end
				mem_pkg::op_sw: write_ref_word(a, w);
				mem_pkg::op_cr_read: res.data[0] = ref_cr[r.addr[3:2]];
				mem_pkg::op_cr_write:
					if (r.addr[3:2] != 2'd0)
						ref_cr[r.addr[3:2]] = w;
				default:
					for (int i = 0; i < mem_pkg::num_lanes; i++)
					begin
						la = r.addr + 32'(i) * r.stride;
						if (r.mask[i] && r.op == mem_pkg::op_vload_strided)
							res.data[i] = ref_word(la[7:0]);
						else if (r.mask[i])
							write_ref_word(la[7:0], r.value[i]);
					end
			endcase
		end
		return res;
	endfunction

	task automatic check_result(input mem_pkg::mem_result_t got, input mem_pkg::mem_result_t exp,
		input int row);
		if (got !== exp)
		begin
			$display("MISMATCH row %0d result: got %h expected %h", row, got, exp);
			errors++;
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input int row);
		if (got !== exp)
		begin
			$display("MISMATCH row %0d ready: got %h expected %h", row, got, exp);
			errors++;
		end
	endtask

	task automatic add_scalar(input mem_pkg::mem_op_t op, input logic [31:0] addr,
		input logic [31:0] value, input logic sq);
		row_t r;
		r = '0;
		r.op = op;
		r.addr = addr;
		r.value[0] = value;
		r.squash = sq;
		rows.push_back(r);
	endtask

	task automatic add_vector(input mem_pkg::mem_op_t op, input logic [31:0] addr,
		input logic [31:0] stride, input logic [3:0] mask, input mem_pkg::vector_t value);
		row_t r;
		r = '0;
		r.op = op;
		r.addr = addr;
		r.stride = stride;
		r.mask = mask;
		r.value = value;
		rows.push_back(r);
	endtask

	task automatic apply_row(input int idx);
		row_t r;
		expect_t e;
		mem_pkg::mem_op_t op_v;
		logic vec_run;
		r = rows[idx];
		op_v = r.op;
		vec_run = 1'b0;
		while (!ready)
		begin
			@(posedge clk);
			#2;
		end
		req = '0;
		req.valid = 1'b1;
		req.op = r.op;
		req.addr = r.addr;
		req.stride = r.stride;
		req.mask = r.mask;
		req.store_value = r.value;
		squash = r.squash;
		if (r.squash)
			$display("row %0d %s squashed, no result expected", idx, op_v.name());
		else
		begin
			e.res = model_access(r);
			vec_run = (op_v == mem_pkg::op_vload_strided || op_v == mem_pkg::op_vstore_strided)
				&& !e.res.fault;
			e.due = cycle + 1 + (vec_run ? mem_pkg::num_lanes + 2 : 2);
			e.row = idx;
			expq.push_back(e);
		end
		@(posedge clk);
		#2;
		req.valid = 1'b0;
		squash = 1'b0;
		if (vec_run)
		begin
			check_ready(ready, 1'b0, idx);
			repeat (mem_pkg::num_lanes - 1)
			begin
				@(posedge clk);
				#2;
				check_ready(ready, 1'b0, idx);
			end
			@(posedge clk);
			#2;
		end
		check_ready(ready, 1'b1, idx);
	endtask

	// Results are compared at the falling edge, where they are stable
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (expq.size() != 0 && expq[0].due < cycle)
			begin
				$display("row %0d: result did not arrive by cycle %0d", expq[0].row, expq[0].due);
				errors++;
				void'(expq.pop_front());
			end
			if (result.valid && expq.size() == 0)
			begin
				$display("Unexpected result at cycle %0d with no request pending", cycle);
				errors++;
			end
			else if (result.valid)
			begin
				got_entry = expq.pop_front();
				errors_before = errors;
				check_result(result, got_entry.res, got_entry.row);
				if (got_entry.due != cycle)
				begin
					$display("row %0d: result arrived at cycle %0d, expected at cycle %0d",
						got_entry.row, cycle, got_entry.due);
					errors++;
				end
				$display("row %0d %s %s", got_entry.row, result.op.name(),
					errors == errors_before ? "ok" : "failed");
			end
		end
	end

	initial
	begin
		wait (limit_time > 0);
		#(limit_time);
		$display("Timeout: results still pending after %0d time units", limit_time);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] sel;
		ref_cr[0] = core_id;
		for (int i = 1; i < 4; i++)
			ref_cr[i] = 32'd0;
		for (int i = 0; i < mem_words; i++)
			add_scalar(mem_pkg::op_sw, 32'(i * 4), 32'(i * 4) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f, 1'b0);
		add_scalar(mem_pkg::op_sw, 32'h40, 32'h8182_8384, 1'b0);
		for (int i = 0; i < 4; i++)
		begin
			add_scalar(mem_pkg::op_lb, 32'h40 + 32'(i), 32'd0, 1'b0);
			add_scalar(mem_pkg::op_lbu, 32'h40 + 32'(i), 32'd0, 1'b0);
		end
		add_scalar(mem_pkg::op_lh, 32'h40, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_lhu, 32'h42, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_sb, 32'h45, 32'h0000_00f0, 1'b0);
		add_scalar(mem_pkg::op_sh, 32'h4a, 32'h0000_9abc, 1'b0);
		add_scalar(mem_pkg::op_lw, 32'h44, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_lw, 32'h48, 32'd0, 1'b0);
		// Alignment faults
		add_scalar(mem_pkg::op_lh, 32'h41, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_sh, 32'h43, 32'h1111_2222, 1'b0);
		add_scalar(mem_pkg::op_sw, 32'h46, 32'h3333_4444, 1'b0);
		add_scalar(mem_pkg::op_lw, 32'h42, 32'd0, 1'b0);
		add_vector(mem_pkg::op_vstore_strided, 32'h80, 32'd6, 4'b1111, {4{32'hdead_beef}});
		add_scalar(mem_pkg::op_lw, 32'h44, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_lw, 32'h80, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_lw, 32'h84, 32'd0, 1'b0);
		// Strided vectors with partial masks
		add_vector(mem_pkg::op_vstore_strided, 32'h80, 32'd8, 4'b1011,
			{32'h4444_4444, 32'h3333_3333, 32'h2222_2222, 32'h1111_1111});
		add_vector(mem_pkg::op_vload_strided, 32'h80, 32'd8, 4'b1111, '0);
		add_vector(mem_pkg::op_vload_strided, 32'h80, 32'd8, 4'b0101, '0);
		add_scalar(mem_pkg::op_lw, 32'h90, 32'd0, 1'b0);
		// Control registers
		add_scalar(mem_pkg::op_cr_read, 32'h0, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_cr_read, 32'h4, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_cr_write, 32'h0, 32'hffff_ffff, 1'b0);
		add_scalar(mem_pkg::op_cr_write, 32'h4, 32'h1234_5678, 1'b0);
		add_scalar(mem_pkg::op_cr_write, 32'hc, 32'hcafe_f00d, 1'b0);
		add_scalar(mem_pkg::op_cr_write, 32'h6, 32'h0bad_0bad, 1'b0);
		add_scalar(mem_pkg::op_cr_read, 32'h0, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_cr_read, 32'h4, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_cr_read, 32'h8, 32'd0, 1'b0);
		add_scalar(mem_pkg::op_cr_read, 32'hc, 32'd0, 1'b0);
		// Squashed requests
		add_scalar(mem_pkg::op_sw, 32'h40, 32'h5555_aaaa, 1'b1);
		add_scalar(mem_pkg::op_lw, 32'h40, 32'd0, 1'b1);
		add_scalar(mem_pkg::op_lw, 32'h40, 32'd0, 1'b0);
		repeat (40)
		begin
			sel = rand_bits(3);
			add_scalar(scalar_ops[sel[2:0]], rand_bits(8), rand_bits(32), 1'b0);
		end
		limit_time = 20 * (rows.size() * (mem_pkg::num_lanes + 4) + 10);

		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++)
			apply_row(i);
		while (expq.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
		$display("%0d rows applied, %0d errors", rows.size(), errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/access_aligner.sv ====
// Byte lane alignment for loads and stores
module access_aligner
(
	input mem_pkg::mem_op_t op,
	input [31:0] addr,
	input [31:0] store_word,
	input mem_pkg::mem_op_t rd_op,
	input [1:0] rd_offset,
	input [31:0] read_word,
	output logic misaligned,
	output logic [3:0] write_bytes,
	output logic [31:0] write_word,
	output logic [31:0] load_word
);
	logic [7:0] rd_byte;
	logic [15:0] rd_half;

	always_comb
	begin
		case (op)
			mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh:
				misaligned = addr[0];
			mem_pkg::op_lw, mem_pkg::op_sw, mem_pkg::op_vload_strided,
			mem_pkg::op_vstore_strided, mem_pkg::op_cr_read, mem_pkg::op_cr_write:
				misaligned = addr[1:0] != 2'b00;
			default:
				misaligned = 1'b0;	// Bytes never fault
		endcase
	end

	// Big-endian, so byte offset 0 is bits 31:24 and mask bit 3
	always_comb
	begin
		write_word = store_word;
		case (op)
			mem_pkg::op_sb:
			begin
				write_word = {4{store_word[7:0]}};
				write_bytes = 4'b1000 >> addr[1:0];
			end
			mem_pkg::op_sh:
			begin
				write_word = {2{store_word[15:0]}};
				write_bytes = addr[1] ? 4'b0011 : 4'b1100;
			end
			mem_pkg::op_sw, mem_pkg::op_vstore_strided:
				write_bytes = 4'b1111;
			default:
				write_bytes = 4'b0000;	// Loads and idle
		endcase
		if (misaligned)
			write_bytes = 4'b0000;
	end

	// Load extraction runs one cycle behind, on the registered read word
	always_comb
	begin
		case (rd_offset)
			2'd0: rd_byte = read_word[31:24];
			2'd1: rd_byte = read_word[23:16];
			2'd2: rd_byte = read_word[15:8];
			default: rd_byte = read_word[7:0];
		endcase
		rd_half = rd_offset[1] ? read_word[15:0] : read_word[31:16];
		case (rd_op)
			mem_pkg::op_lb: load_word = {{24{rd_byte[7]}}, rd_byte};
			mem_pkg::op_lbu: load_word = {24'd0, rd_byte};
			mem_pkg::op_lh: load_word = {{16{rd_half[15]}}, rd_half};
			mem_pkg::op_lhu: load_word = {16'd0, rd_half};
			mem_pkg::op_lw, mem_pkg::op_vload_strided: load_word = read_word;
			default: load_word = 32'd0;	// Masked lanes and non-loads read zero
		endcase
	end

endmodule

// ==== verilog/access_sequencer.sv ====
// Load/store access sequencer
module access_sequencer
(
	input clk,
	input reset,
	input mem_pkg::mem_req_t req,
	input squash,
	input misaligned,
	input [31:0] load_word,
	input [31:0] cr_read_value,
	input [1:0] lane,
	input [31:0] lane_addr,
	input last,
	output logic ready,
	output logic start,
	output logic step,
	output mem_pkg::mem_op_t acc_op,
	output logic [31:0] acc_addr,
	output logic [31:0] acc_store_word,
	output mem_pkg::mem_op_t rd_op,
	output logic [1:0] rd_offset,
	output logic [1:0] cr_index,
	output logic cr_write,
	output logic [31:0] cr_write_value,
	output mem_pkg::mem_result_t result
);
	// One access in flight between memory issue and result
	typedef struct packed
	{
		logic valid;
		mem_pkg::mem_op_t op;	// Access op, idle when suppressed or masked
		mem_pkg::mem_op_t res_op;	// Op reported in the result
		logic [1:0] offset;
		logic fault;
		logic vec;	// Vector lane, gathered rather than reported
		logic [1:0] lane;
		logic last;
		logic [31:0] word;
	} stage_t;

	mem_pkg::seq_state_t state;
	mem_pkg::seq_state_t state_next;
	mem_pkg::mem_op_t vec_op;
	logic [mem_pkg::num_lanes-1:0] vec_mask;
	mem_pkg::vector_t vec_store;
	stage_t p0_next;
	stage_t p0;
	stage_t p1;
	mem_pkg::vector_t gather_data;
	mem_pkg::mem_op_t gather_op;
	logic gather_done;
	mem_pkg::mem_result_t result_next;
	logic take;
	logic is_vec;
	logic vec_fault;

	assign ready = state == mem_pkg::st_idle;
	assign take = req.valid && ready && !squash;
	assign is_vec = req.op == mem_pkg::op_vload_strided
		|| req.op == mem_pkg::op_vstore_strided;
	assign vec_fault = is_vec && (req.addr[1:0] != 2'b00 || req.stride[1:0] != 2'b00);
	assign start = take && is_vec && !vec_fault;
	assign step = state == mem_pkg::st_lanes;

	assign rd_op = p0.op;
	assign rd_offset = p0.offset;
	assign cr_index = acc_addr[3:2];	// Word-aligned register index
	assign cr_write = acc_op == mem_pkg::op_cr_write && !misaligned;
	assign cr_write_value = acc_store_word;

	// Access mux and next state
	always_comb
	begin
		acc_addr = lane_addr;
		acc_store_word = vec_store[lane];
		acc_op = mem_pkg::op_nop;
		state_next = mem_pkg::st_idle;
		case (state)
			mem_pkg::st_idle:
			begin
				acc_addr = req.addr;
				acc_store_word = req.store_value[0];
				if (take && !vec_fault && (!is_vec || req.mask[0]))
					acc_op = req.op;
				if (start)
					state_next = mem_pkg::st_lanes;
			end
			mem_pkg::st_lanes:
			begin
				acc_op = vec_mask[lane] ? vec_op : mem_pkg::op_nop;
				state_next = last ? mem_pkg::st_drain : mem_pkg::st_lanes;
			end
			default:
				state_next = mem_pkg::st_idle;	// Final lane read lands here
		endcase
	end

	always_comb
	begin
		p0_next = '0;
		if (state == mem_pkg::st_idle)
		begin
			p0_next.valid = take;
			p0_next.fault = is_vec ? vec_fault : misaligned;
			p0_next.op = p0_next.fault ? mem_pkg::op_nop : acc_op;
			p0_next.res_op = req.op;
			p0_next.offset = req.addr[1:0];
			p0_next.vec = start;
			if (req.op == mem_pkg::op_cr_read)
				p0_next.word = cr_read_value;
		end
		else if (state == mem_pkg::st_lanes)
		begin
			p0_next.valid = 1'b1;
			p0_next.op = acc_op;
			p0_next.res_op = vec_op;
			p0_next.offset = lane_addr[1:0];
			p0_next.vec = 1'b1;
			p0_next.lane = lane;
			p0_next.last = last;
		end
	end

	// Scalars report from p1, vectors one cycle later from the gather register
	always_comb
	begin
		result_next = '0;
		if (gather_done)
		begin
			result_next.valid = 1'b1;
			result_next.op = gather_op;
			result_next.data = gather_data;
		end
		else
		begin
			result_next.valid = p1.valid && !p1.vec;
			result_next.op = p1.res_op;
			result_next.fault = p1.fault;
			result_next.data[0] = p1.word;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= mem_pkg::st_idle;
			p0 <= '0;
			p1 <= '0;
			gather_done <= 1'b0;
			result <= '0;
		end
		else
		begin
			state <= state_next;
			p0 <= p0_next;
			p1 <= p0;
			if (p0.op != mem_pkg::op_cr_read)
				p1.word <= load_word;
			gather_done <= p1.valid && p1.vec && p1.last;
			result <= result_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			vec_op <= req.op;
			vec_mask <= req.mask;
			vec_store <= req.store_value;
		end
		if (p1.valid && p1.vec)
		begin
			gather_data[p1.lane] <= p1.word;
			gather_op <= p1.res_op;
		end
	end

endmodule

// ==== verilog/control_regs.sv ====
// Control register file
module control_regs
#(
	parameter logic [31:0] core_id = 32'd0
)
(
	input clk,
	input reset,
	input [1:0] cr_index,
	input cr_write,
	input [31:0] cr_write_value,
	output logic [31:0] cr_read_value
);
	logic [31:0] scratch [1:3];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < 4; i++)
				scratch[i] <= 32'd0;
		end
		else if (cr_write && cr_index != 2'd0)	// Register 0 is read-only
			scratch[cr_index] <= cr_write_value;
	end

	assign cr_read_value = cr_index == 2'd0 ? core_id : scratch[cr_index];

endmodule

// ==== verilog/data_memory.sv ====
// Local data memory
module data_memory
#(
	parameter int mem_words = 64
)
(
	input clk,
	input [31:0] addr,
	input [3:0] write_bytes,
	input [31:0] write_word,
	output logic [31:0] read_word
);
	localparam int index_bits = $clog2(mem_words);

	logic [31:0] mem [mem_words];
	logic [index_bits-1:0] index;

	assign index = addr[index_bits+1:2];	// Word index, wraps at the depth

	// Read returns the old word when written in the same cycle
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (write_bytes[i])
				mem[index][8*i +: 8] <= write_word[8*i +: 8];
		end
		read_word <= mem[index];
	end

endmodule

// ==== verilog/lane_counter.sv ====
// Strided lane address counter
module lane_counter
(
	input clk,
	input reset,
	input start,
	input step,
	input [31:0] base,
	input [31:0] stride,
	output logic [1:0] lane,
	output logic [31:0] lane_addr,
	output logic last
);
	logic [31:0] stride_q;

	// Lane 0 goes out with the request itself, so start lands on lane 1
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			lane <= 2'd0;
			lane_addr <= 32'd0;
			stride_q <= 32'd0;
		end
		else if (start)
		begin
			lane <= 2'd1;
			lane_addr <= base + stride;
			stride_q <= stride;
		end
		else if (step)
		begin
			lane <= lane + 2'd1;
			lane_addr <= lane_addr + stride_q;
		end
	end

	assign last = lane == 2'(mem_pkg::num_lanes - 1);

endmodule

// ==== verilog/mem_access_unit.sv ====
// Load/store stage top level
module mem_access_unit
#(
	parameter int mem_words = 64,
	parameter logic [31:0] core_id = 32'd0
)
(
	input clk,
	input reset,
	input mem_pkg::mem_req_t req,
	input squash,
	output logic ready,
	output mem_pkg::mem_result_t result
);
	logic start;
	logic step;
	logic last;
	logic [1:0] lane;
	logic [31:0] lane_addr;
	mem_pkg::mem_op_t acc_op;
	mem_pkg::mem_op_t rd_op;
	logic [1:0] rd_offset;
	logic [31:0] acc_addr;
	logic [31:0] acc_store_word;
	logic misaligned;
	logic [3:0] write_bytes;
	logic [31:0] write_word;
	logic [31:0] read_word;
	logic [31:0] load_word;
	logic [1:0] cr_index;
	logic cr_write;
	logic [31:0] cr_write_value;
	logic [31:0] cr_read_value;

	access_sequencer access_sequencer_inst
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.squash(squash),
		.misaligned(misaligned),
		.load_word(load_word),
		.cr_read_value(cr_read_value),
		.lane(lane),
		.lane_addr(lane_addr),
		.last(last),
		.ready(ready),
		.start(start),
		.step(step),
		.acc_op(acc_op),
		.acc_addr(acc_addr),
		.acc_store_word(acc_store_word),
		.rd_op(rd_op),
		.rd_offset(rd_offset),
		.cr_index(cr_index),
		.cr_write(cr_write),
		.cr_write_value(cr_write_value),
		.result(result)
	);

	lane_counter lane_counter_inst
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.step(step),
		.base(req.addr),
		.stride(req.stride),
		.lane(lane),
		.lane_addr(lane_addr),
		.last(last)
	);

	access_aligner access_aligner_inst
	(
		.op(acc_op),
		.addr(acc_addr),
		.store_word(acc_store_word),
		.rd_op(rd_op),
		.rd_offset(rd_offset),
		.read_word(read_word),
		.misaligned(misaligned),
		.write_bytes(write_bytes),
		.write_word(write_word),
		.load_word(load_word)
	);

	data_memory #(.mem_words(mem_words)) data_memory_inst
	(
		.clk(clk),
		.addr(acc_addr),
		.write_bytes(write_bytes),
		.write_word(write_word),
		.read_word(read_word)
	);

	control_regs #(.core_id(core_id)) control_regs_inst
	(
		.clk(clk),
		.reset(reset),
		.cr_index(cr_index),
		.cr_write(cr_write),
		.cr_write_value(cr_write_value),
		.cr_read_value(cr_read_value)
	);

endmodule

// ==== verilog/mem_pkg.sv ====
// Load/store stage types
package mem_pkg;

	localparam int num_lanes = 4;	// Vector width in 32-bit lanes

	typedef enum logic [3:0]
	{
		op_nop,
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_sb,
		op_sh,
		op_sw,
		op_vload_strided,
		op_vstore_strided,
		op_cr_read,
		op_cr_write
	} mem_op_t;

	// Lane 0 carries scalar values
	typedef logic [num_lanes-1:0][31:0] vector_t;

	typedef struct packed
	{
		logic valid;
		mem_op_t op;
		logic [31:0] addr;	// Byte address, or register index in bits 3:2
		logic [31:0] stride;	// Bytes between vector lanes
		logic [num_lanes-1:0] mask;
		vector_t store_value;
	} mem_req_t;

	typedef struct packed
	{
		logic valid;
		mem_op_t op;
		logic fault;	// Alignment fault, access was suppressed
		vector_t data;
	} mem_result_t;

	typedef enum logic [1:0]
	{
		st_idle,
		st_lanes,
		st_drain
	} seq_state_t;

endpackage
